// ==== hdl/link_config.svh ====
`ifndef LINK_CONFIG_SVH
`define LINK_CONFIG_SVH

// Clock cycles per serial bit.
// Kept short for simulation. A 48 MHz board running at 1 Mbaud would use 48.
`define LINK_BAUD_DIV 16

// Quiet time in clock cycles between reset release and the hello byte.
`define LINK_STARTUP_CYCLES 64

// Byte announced once the start-up delay has passed.
`define LINK_HELLO_BYTE 8'hA5

// Answer sent back for a frame that arrived with bad parity.
`define LINK_NAK_BYTE 8'h15

`endif

// ==== hdl/link_pkg.sv ====
package link_pkg;

    // One data byte as it travels over the link.
    typedef logic [7:0] byte_t;

    // ****************************************
    // Frame sequencing shared by both engines.
    // ****************************************

    // A frame is start, eight data bits, even parity and stop.
    typedef enum logic [2:0] {
        IDLE,   // Line held high, no frame in progress.
        START,  // Start bit, always low.
        DATA,   // Eight data bits, LSB first.
        PARITY, // Even parity over the data bits.
        STOP    // Stop bit, always high.
    } frame_phase_t;

    // Controller states, from power-up quiet time to normal echo service.
    typedef enum logic [1:0] {
        STARTUP, // Quiet time after reset.
        HELLO,   // Hello byte has been handed to the transmitter.
        READY,   // Reply slot empty.
        REPLY    // Reply slot full and waiting for the transmitter.
    } link_state_t;

endpackage

// ==== hdl/uart_byte_if.sv ====
`timescale 1ns/1ps

interface uart_byte_if;

    // Receive side, written by the receiver.
    link_pkg::byte_t rx_data;         // Last byte received, held until the next frame.
    logic            rx_done;         // One-cycle pulse when a frame is complete.
    logic            rx_parity_error; // Parity of the last frame did not match.

    // Transmit side.
    link_pkg::byte_t tx_data;  // Byte to send, captured on tx_start.
    logic            tx_start; // One-cycle request from the controller.
    logic            tx_busy;  // High while a frame is on the line.

    // The receiver only produces byte-level results.
    modport rx_side (output rx_data, rx_done, rx_parity_error);

    // The transmitter takes a byte and reports when the line is in use.
    modport tx_side (input tx_data, tx_start, output tx_busy);

    // The controller sits between the two engines.
    modport ctrl (
        input  rx_data, rx_done, rx_parity_error, tx_busy,
        output tx_data, tx_start
    );

endinterface

// ==== hdl/uart_tx.sv ====
`timescale 1ns/1ps
`include "link_config.svh"

module uart_tx (
    input  logic         clk,
    input  logic         rst_n,
    uart_byte_if.tx_side bus,
    output logic         tx
);

    localparam int BAUD_DIV = `LINK_BAUD_DIV;
    localparam int CNT_W    = $clog2(BAUD_DIV);
    localparam logic [CNT_W-1:0] BAUD_LAST = CNT_W'(BAUD_DIV - 1);

    link_pkg::frame_phase_t phase; // Which part of the frame is on the line.
    logic [CNT_W-1:0] baud_cnt;    // Cycles spent in the current bit.
    logic [2:0]       bit_cnt;     // Data bit index.
    link_pkg::byte_t  shift_q;     // Next data bit always sits in bit 0.
    logic             parity_q;    // Even parity of the captured byte.
    logic             bit_end;     // Last cycle of the current bit.

    assign bit_end     = (baud_cnt == BAUD_LAST);
    assign bus.tx_busy = (phase != link_pkg::IDLE); // Rises the cycle after tx_start.

    // ****************************************
    // Frame sequencer and line driver.
    // ****************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase    <= link_pkg::IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            tx       <= 1'b1; // Idle level.
        end else begin
            if (phase != link_pkg::IDLE) begin
                baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
            end
            case (phase)
                link_pkg::IDLE: begin
                    if (bus.tx_start) begin
                        phase    <= link_pkg::START;
                        baud_cnt <= '0;
                        tx       <= 1'b0; // Start bit goes out with busy.
                    end
                end
                link_pkg::START: begin
                    if (bit_end) begin
                        phase   <= link_pkg::DATA;
                        bit_cnt <= '0;
                        tx      <= shift_q[0]; // LSB first.
                    end
                end
                link_pkg::DATA: begin
                    if (bit_end) begin
                        if (bit_cnt == 3'd7) begin
                            phase <= link_pkg::PARITY;
                            tx    <= parity_q;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            tx      <= shift_q[0];
                        end
                    end
                end
                link_pkg::PARITY: begin
                    if (bit_end) begin
                        phase <= link_pkg::STOP;
                        tx    <= 1'b1; // Stop bit.
                    end
                end
                default: begin
                    if (bit_end) begin
                        phase <= link_pkg::IDLE; // Line stays high.
                    end
                end
            endcase
        end
    end

    // Byte capture and shifting. The shift runs one step ahead of the line.
    always_ff @(posedge clk) begin
        if (phase == link_pkg::IDLE && bus.tx_start) begin
            shift_q  <= bus.tx_data;
            parity_q <= ^bus.tx_data; // Even parity makes the ones count even.
        end else if (bit_end && (phase == link_pkg::START || phase == link_pkg::DATA)) begin
            shift_q <= shift_q >> 1;
        end
    end

endmodule

// ==== hdl/uart_rx.sv ====
`timescale 1ns/1ps
`include "link_config.svh"

module uart_rx (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         rx,
    uart_byte_if.rx_side bus
);

    localparam int BAUD_DIV = `LINK_BAUD_DIV;
    localparam int CNT_W    = $clog2(BAUD_DIV);
    localparam logic [CNT_W-1:0] BAUD_LAST = CNT_W'(BAUD_DIV - 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(BAUD_DIV / 2 - 1);

    logic [1:0]       sync_q;    // Two-stage synchroniser for the async line.
    logic             rx_s;      // Synchronised line level.
    logic             rx_prev;   // Line level one cycle earlier.
    link_pkg::frame_phase_t phase;
    logic [CNT_W-1:0] baud_cnt;
    logic [2:0]       bit_cnt;
    link_pkg::byte_t  shift_q;   // Data bits enter at the top and move down.
    logic             parity_q;  // Parity bit as received.
    logic             sample_now; // Middle of the current bit.
    logic             stop_ok;   // Stop bit sampled high.

    assign rx_s = sync_q[1];

    // The start bit is sampled half a bit in, every later bit one full bit later.
    assign sample_now = (phase == link_pkg::START) ? (baud_cnt == HALF_LAST)
                                                   : (baud_cnt == BAUD_LAST);
    assign stop_ok    = (phase == link_pkg::STOP) && sample_now && rx_s;

    // ****************************************
    // Synchroniser and frame sequencer.
    // ****************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_q      <= 2'b11; // Line idles high so no false edge after reset.
            rx_prev     <= 1'b1;
            phase       <= link_pkg::IDLE;
            baud_cnt    <= '0;
            bit_cnt     <= '0;
            bus.rx_done <= 1'b0;
        end else begin
            sync_q      <= {sync_q[0], rx};
            rx_prev     <= rx_s;
            bus.rx_done <= 1'b0; // Pulse lasts one cycle.
            if (phase != link_pkg::IDLE) begin
                baud_cnt <= sample_now ? '0 : baud_cnt + 1'b1;
            end
            case (phase)
                link_pkg::IDLE: begin
                    if (rx_prev && !rx_s) begin // Falling edge opens a frame.
                        phase    <= link_pkg::START;
                        baud_cnt <= '0;
                    end
                end
                link_pkg::START: begin
                    if (sample_now) begin
                        // A high line at mid start bit was only a glitch.
                        phase   <= rx_s ? link_pkg::IDLE : link_pkg::DATA;
                        bit_cnt <= '0;
                    end
                end
                link_pkg::DATA: begin
                    if (sample_now) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            phase <= link_pkg::PARITY;
                        end
                    end
                end
                link_pkg::PARITY: begin
                    if (sample_now) begin
                        phase <= link_pkg::STOP;
                    end
                end
                default: begin
                    if (sample_now) begin
                        phase       <= link_pkg::IDLE;
                        bus.rx_done <= rx_s; // A low stop bit drops the frame silently.
                    end
                end
            endcase
        end
    end

    // Payload path. Results change only when a frame closes with a good stop bit.
    always_ff @(posedge clk) begin
        if (phase == link_pkg::DATA && sample_now) begin
            shift_q <= {rx_s, shift_q[7:1]};
        end
        if (phase == link_pkg::PARITY && sample_now) begin
            parity_q <= rx_s;
        end
        if (stop_ok) begin
            bus.rx_data         <= shift_q;
            bus.rx_parity_error <= parity_q ^ (^shift_q); // Nonzero means odd ones count.
        end
    end

endmodule

// ==== hdl/link_ctrl.sv ====
`timescale 1ns/1ps
`include "link_config.svh"

module link_ctrl (
    input  logic      clk,
    input  logic      rst_n,
    uart_byte_if.ctrl bus,
    output logic      led_red,
    output logic      led_green,
    output logic      led_blue
);

    localparam int STARTUP_CYCLES = `LINK_STARTUP_CYCLES;
    localparam int WAIT_W = $clog2(STARTUP_CYCLES);
    localparam logic [WAIT_W-1:0] WAIT_LAST = WAIT_W'(STARTUP_CYCLES - 1);

    link_pkg::link_state_t state;
    logic [WAIT_W-1:0] wait_cnt;   // Start-up quiet time counter.
    link_pkg::byte_t   slot_q;     // The one pending reply byte.
    link_pkg::byte_t   reply_byte; // Echo or NAK for the byte just received.
    logic              hello_go;   // Quiet time is over this cycle.
    logic              send_now;   // Pending slot goes to the transmitter.
    logic              slot_load;  // Received byte is accepted into the slot.
    logic              led_event;  // A byte arrived after the hello.

    assign reply_byte = bus.rx_parity_error ? `LINK_NAK_BYTE : bus.rx_data;
    assign hello_go   = (state == link_pkg::STARTUP) && (wait_cnt == WAIT_LAST);

    // The held tx_start check covers the cycle before tx_busy rises.
    assign send_now   = (state == link_pkg::REPLY) && !bus.tx_busy && !bus.tx_start;

    // A full slot that is not leaving this cycle drops the newest byte.
    assign slot_load  = bus.rx_done && (state == link_pkg::READY || send_now);
    assign led_event  = bus.rx_done && (state == link_pkg::READY || state == link_pkg::REPLY);

    // ****************************************
    // Controller FSM and LED drivers.
    // ****************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= link_pkg::STARTUP;
            wait_cnt     <= '0;
            bus.tx_start <= 1'b0;
            led_red      <= 1'b1; // LEDs are active low, all off.
            led_green    <= 1'b1;
            led_blue     <= 1'b1;
        end else begin
            bus.tx_start <= 1'b0;
            case (state)
                link_pkg::STARTUP: begin
                    wait_cnt <= wait_cnt + 1'b1;
                    if (hello_go) begin
                        state        <= link_pkg::HELLO;
                        bus.tx_start <= 1'b1;
                        led_green    <= 1'b0; // Link is up.
                    end
                end
                link_pkg::HELLO: begin
                    if (bus.tx_busy) begin // Hello is on the line.
                        state <= link_pkg::READY;
                    end
                end
                link_pkg::READY: begin
                    if (slot_load) begin
                        state <= link_pkg::REPLY;
                    end
                end
                default: begin
                    if (send_now) begin
                        bus.tx_start <= 1'b1;
                        state <= slot_load ? link_pkg::REPLY : link_pkg::READY;
                    end
                end
            endcase
            if (led_event) begin
                if (bus.rx_parity_error) begin
                    led_red <= 1'b0;
                end else begin
                    led_red  <= 1'b1;      // A good byte clears the error light.
                    led_blue <= ~led_blue; // Blue follows the good byte count.
                end
            end
        end
    end

    // Outgoing byte and reply slot.
    always_ff @(posedge clk) begin
        if (hello_go) begin
            bus.tx_data <= `LINK_HELLO_BYTE;
        end else if (send_now) begin
            bus.tx_data <= slot_q;
        end
        if (slot_load) begin
            slot_q <= reply_byte;
        end
    end

endmodule

// ==== hdl/link_top.sv ====
`timescale 1ns/1ps

module link_top (
    input  logic clk,
    input  logic rst_n,
    input  logic rx,
    output logic tx,
    output logic led_red,
    output logic led_green,
    output logic led_blue
);

    // Byte-level link between the serial engines and the controller.
    uart_byte_if bus ();

    // ****************************************
    // Serial engines.
    // ****************************************

    uart_rx u_rx (
        .clk   (clk),
        .rst_n (rst_n),
        .rx    (rx),
        .bus   (bus.rx_side)
    );

    uart_tx u_tx (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (bus.tx_side),
        .tx    (tx)
    );

    // Start-up, echo and status lights.
    link_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (bus.ctrl),
        .led_red   (led_red),
        .led_green (led_green),
        .led_blue  (led_blue)
    );

endmodule

// ==== testbench/link_asserts.sv ====
`timescale 1ns/1ps

module link_asserts (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   tx,        // Serial output of the DUT.
    input link_pkg::frame_phase_t tx_phase,  // Transmitter frame phase.
    input link_pkg::link_state_t  ctrl_state, // Controller state.
    input logic                   tx_start,
    input logic                   tx_busy,
    input logic                   rx_done
);

    // ****************************************
    // Serial line level.
    // ****************************************

    // An idle transmitter leaves the line at the stop level.
    tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
        tx_phase == link_pkg::IDLE |-> tx)
        else $error("tx line is low while the transmitter is idle");

    // The line stays high through the quiet time after reset.
    quiet_startup: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl_state == link_pkg::STARTUP |-> tx)
        else $error("tx line left idle during the start-up quiet time");

    // ****************************************
    // Strobe rules on the byte interface.
    // ****************************************

    // A new frame is only requested once the line is free.
    start_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
        tx_start |-> !tx_busy)
        else $error("tx_start pulsed while the transmitter was busy");

    rx_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        rx_done |=> !rx_done)
        else $error("rx_done stayed high for more than one cycle"); // One frame, one pulse.

endmodule

// Every link_top carries the checker.
bind link_top link_asserts u_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .tx         (tx),
    .tx_phase   (u_tx.phase),
    .ctrl_state (u_ctrl.state),
    .tx_start   (bus.tx_start),
    .tx_busy    (bus.tx_busy),
    .rx_done    (bus.rx_done)
);

// ==== testbench/link_tb.sv ====
`timescale 1ns/1ps
`include "link_config.svh"

module link_tb;

    localparam int BAUD_DIV = `LINK_BAUD_DIV;
    localparam int FRAME    = 11 * BAUD_DIV; // Cycles per serial frame.
    localparam int LIMIT    = 2 * (`LINK_STARTUP_CYCLES + 40 * FRAME);

    logic clk;
    logic rst_n;
    logic rx;
    logic tx;
    logic led_red;
    logic led_green;
    logic led_blue;
    integer seed;                // Random state, fixed start value.
    int errors;
    int passes;
    int test_errors;             // Error count when the current test began.
    int cycles;
    int good_count;              // Good bytes sent since reset.
    int low_cycles;              // Quiet-time cycles that saw tx low.
    logic red_exp;               // Model of the red LED level.
    link_pkg::byte_t exp_q[$];   // Replies the model predicts.
    link_pkg::byte_t got_q[$];   // Bytes decoded from tx.

    link_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx        (rx),
        .tx        (tx),
        .led_red   (led_red),
        .led_green (led_green),
        .led_blue  (led_blue)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Hard limit on the run length.
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
            errors++;
        end else begin
            passes++;
        end
    endtask

    // ****************************************
    // Serial line model and reply prediction.
    // ****************************************

    task automatic send_and_predict(input link_pkg::byte_t value, input logic bad_parity,
                                    input logic bad_stop);
        logic [10:0] bits;
        bits = {~bad_stop, (^value) ^ bad_parity, value, 1'b0}; // Bit 0 goes out first.
        if (!bad_stop && bad_parity) begin
            exp_q.push_back(`LINK_NAK_BYTE); // Bad parity earns a NAK and the red light.
            red_exp = 1'b0;
        end else if (!bad_stop) begin
            exp_q.push_back(value);
            red_exp = 1'b1;
            good_count++;
        end
        for (int i = 0; i < 11; i++) begin
            @(posedge clk);
            rx <= bits[i];
            repeat (BAUD_DIV - 1) @(posedge clk);
        end
        if (bad_stop) begin
            @(posedge clk);
            rx <= 1'b1; // Back to idle after a low stop bit.
        end
    endtask

    task automatic idle_bits(input int count);
        repeat (count * BAUD_DIV) @(posedge clk);
    endtask

    // Waits for every predicted reply, then checks bytes and LEDs.
    task automatic collect_replies(input string name);
        while (got_q.size() < exp_q.size()) @(negedge clk);
        while (exp_q.size() > 0) compare(name, exp_q.pop_front(), got_q.pop_front());
        compare({name, " extra replies"}, 0, got_q.size());
        compare({name, " led_red"}, red_exp, led_red);
        compare({name, " led_blue"}, 32'(good_count % 2 == 0), led_blue); // Off when even.
    endtask

    task automatic finish_test(input string name);
        $display("test %s finished with %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    // Decodes tx frames at mid-bit.
    initial begin : tx_monitor
        logic prev;
        logic par;
        link_pkg::byte_t value;
        prev = 1'b1;
        forever begin
            @(negedge clk);
            if (rst_n && prev && !tx) begin
                repeat (BAUD_DIV / 2) @(negedge clk); // Middle of the start bit.
                for (int i = 0; i < 8; i++) begin
                    repeat (BAUD_DIV) @(negedge clk);
                    value[i] = tx;
                end
                repeat (BAUD_DIV) @(negedge clk);
                par = tx;
                repeat (BAUD_DIV) @(negedge clk);
                if (!tx || par !== ^value) begin
                    $display("Frame on tx has a wrong parity or stop bit");
                    errors++;
                end
                got_q.push_back(value);
            end
            prev = tx;
        end
    end

    // ****************************************
    // Test sequence.
    // ****************************************

    initial begin
        seed = 32'hd8119473;
        rst_n = 1'b0;
        rx = 1'b1; // Line idles high.
        errors = 0;
        passes = 0;
        test_errors = 0;
        cycles = 0;
        good_count = 0;
        low_cycles = 0;
        red_exp = 1'b1;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        // The line must stay idle for the whole quiet time.
        repeat (`LINK_STARTUP_CYCLES) begin
            @(negedge clk);
            if (!tx) begin
                low_cycles++;
            end
        end
        compare("startup quiet line", 0, low_cycles);
        compare("startup led_green before hello", 1, led_green);
        while (got_q.size() == 0) @(negedge clk);
        repeat (2 * FRAME) @(negedge clk); // Nothing else may follow the hello.
        compare("startup byte count", 1, got_q.size());
        compare("startup hello", `LINK_HELLO_BYTE, got_q.pop_front());
        compare("startup led_green", 0, led_green);
        finish_test("startup");

        for (int i = 0; i < 12; i++) begin
            send_and_predict(8'($random(seed)), 1'b0, 1'b0);
            idle_bits(1 + ($random(seed) & 3));
        end
        collect_replies("echo");
        finish_test("echo");

        send_and_predict(8'($random(seed)), 1'b1, 1'b0);
        collect_replies("parity nak");
        send_and_predict(8'($random(seed)), 1'b0, 1'b0);
        collect_replies("parity recover");
        finish_test("parity");

        for (int i = 0; i < 6; i++) begin
            send_and_predict(8'($random(seed)), ($random(seed) & 3) == 0, 1'b0);
            collect_replies("blue led");
        end
        finish_test("blue led");

        for (int i = 0; i < 10; i++) begin
            send_and_predict(8'($random(seed)), 1'b0, 1'b0); // No gap between frames.
        end
        collect_replies("stream");
        finish_test("stream");

        send_and_predict(8'($random(seed)), 1'b0, 1'b1);
        repeat (2 * FRAME) @(negedge clk);
        compare("framing silent", 0, got_q.size());
        send_and_predict(8'($random(seed)), 1'b0, 1'b0);
        collect_replies("framing recover");
        finish_test("framing");

        $display("%0d checks passed, %0d errors", passes, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+hdl
hdl/link_pkg.sv
hdl/uart_byte_if.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/link_ctrl.sv
hdl/link_top.sv
testbench/link_asserts.sv
testbench/link_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := link_tb
FILELIST  := list.f
BUILD     := obj_dir
SIM       := link_sim
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(SIM)
	./$(BUILD)/$(SIM) | tee $(LOG)
	grep -qx "NO ERRORS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
